// File: eth_beacon_top.f
rtl/eth_pkg.sv
rtl/beacon_pkg.sv
rtl/send_ctl_if.sv
rtl/payload_gen.sv
rtl/byte_fifo.sv
rtl/beacon_sequencer.sv
rtl/frame_sender.sv
rtl/eth_beacon_top.sv
verification/eth_beacon_props.sv
verification/tb_eth_beacon.sv

// File: rtl/beacon_pkg.sv
package beacon_pkg;

    // beacon cycle
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT,
        ST_FILL,
        ST_SEND,
        ST_REST,
        ST_DONE
    } seq_state_t;

    // arp body length before padding
    localparam logic [15:0] ARP_LEN = 16'd28;

endpackage

// File: rtl/beacon_sequencer.sv
module beacon_sequencer #(
    parameter logic [15:0] PAYLOAD_LEN = 16'd64,
    parameter logic [31:0] REST_CYCLES = 32'd125_000_000
) (
    input  logic        e_grxc,
    input  logic        rst,
    input  logic        fill_done,
    output logic        fill_start,
    output logic [15:0] fill_len,
    send_ctl_if.seq     ctl
);
    import eth_pkg::*;
    import beacon_pkg::*;

    seq_state_t  state;
    seq_state_t  next_state;
    logic [31:0] rest_cnt;
    frame_kind_t kind;
    logic [15:0] len;

    assign len        = (kind == FK_ARP) ? ARP_LEN : PAYLOAD_LEN;
    assign fill_len   = len;
    assign fill_start = (state == ST_FILL);
    assign ctl.start  = (state == ST_SEND);
    assign ctl.kind   = kind;
    assign ctl.len    = len;

    always_comb begin
        case (state)
            ST_IDLE: next_state = ST_WAIT;
            ST_WAIT: next_state = ST_FILL;
            ST_FILL: next_state = fill_done ? ST_SEND : ST_FILL;
            ST_SEND: next_state = ctl.done ? ST_REST : ST_SEND;
            ST_REST: next_state = (rest_cnt == REST_CYCLES - 32'd1) ? ST_DONE : ST_REST;
            ST_DONE: next_state = ST_WAIT;
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge e_grxc or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            rest_cnt <= '0;
            kind     <= FK_ARP; // first frame after reset
        end else begin
            state <= next_state;
            if (state == ST_REST) rest_cnt <= rest_cnt + 32'd1;
            else rest_cnt <= '0;
            if (state == ST_DONE) kind <= (kind == FK_ARP) ? FK_IPV4 : FK_ARP;
        end
    end

endmodule

// File: rtl/byte_fifo.sv
module byte_fifo #(
    parameter int FIFO_DEPTH = 128
) (
    input  logic       e_grxc,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       full,
    output logic       empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [7:0]  mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr; // msb is the wrap bit
    logic [AW:0] rd_ptr;
    logic        do_wr;
    logic        do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge e_grxc or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge e_grxc) begin
        if (do_wr) mem[wr_ptr[AW-1:0]] <= wr_data;
        if (do_rd) rd_data <= mem[rd_ptr[AW-1:0]]; // registered read
    end

endmodule

// File: rtl/eth_beacon_top.sv
module eth_beacon_top #(
    parameter logic [15:0] PAYLOAD_LEN = 16'd64,
    parameter logic [31:0] REST_CYCLES = 32'd125_000_000,
    parameter int          FIFO_DEPTH  = 128
) (
    input  logic       e_grxc,
    input  logic       rst,
    output logic       e_gtxc,
    output logic       e_txen,
    output logic       e_txer,
    output logic [7:0] e_txd
);

    logic        fill_start;
    logic [15:0] fill_len;
    logic        fill_done;
    logic        wr_en;
    logic [7:0]  wr_data;
    logic        full;
    logic        rd_en;
    logic [7:0]  rd_data;
    logic        empty;

    assign e_gtxc = e_grxc; // single clock, tx forwarded from rx

    send_ctl_if u_ctl ();

    beacon_sequencer #(
        .PAYLOAD_LEN (PAYLOAD_LEN),
        .REST_CYCLES (REST_CYCLES)
    ) u_seq (
        .e_grxc     (e_grxc),
        .rst        (rst),
        .fill_done  (fill_done),
        .fill_start (fill_start),
        .fill_len   (fill_len),
        .ctl        (u_ctl.seq)
    );

    payload_gen u_gen (
        .e_grxc     (e_grxc),
        .rst        (rst),
        .fill_start (fill_start),
        .fill_len   (fill_len),
        .full       (full),
        .fill_done  (fill_done),
        .wr_en      (wr_en),
        .wr_data    (wr_data)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .e_grxc  (e_grxc),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (full),
        .empty   (empty)
    );

    frame_sender u_snd (
        .e_grxc  (e_grxc),
        .rst     (rst),
        .rd_data (rd_data),
        .empty   (empty),
        .rd_en   (rd_en),
        .e_txen  (e_txen),
        .e_txer  (e_txer),
        .e_txd   (e_txd),
        .ctl     (u_ctl.snd)
    );

endmodule

// File: rtl/eth_pkg.sv
package eth_pkg;

    // frame opcode, alternates each beacon
    typedef enum logic {
        FK_ARP,
        FK_IPV4
    } frame_kind_t;

    // ##############################
    // ethertypes and addresses
    // ##############################
    localparam logic [15:0] ETH_TYPE_ARP  = 16'h0806;
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

    localparam logic [47:0] MAC_DST = 48'hFFFF_FFFF_FFFF; // broadcast
    localparam logic [47:0] MAC_SRC = 48'h000A_3501_0203;

    // ##############################
    // framing
    // ##############################
    localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  SFD_BYTE      = 8'hD5;
    localparam logic [15:0] MIN_PAYLOAD   = 16'd46;

    // reflected form, lsb first
    localparam logic [31:0] CRC32_POLY = 32'hEDB8_8320;

endpackage

// File: rtl/frame_sender.sv
module frame_sender (
    input  logic       e_grxc,
    input  logic       rst,
    input  logic [7:0] rd_data,
    input  logic       empty,
    output logic       rd_en,
    output logic       e_txen,
    output logic       e_txer,
    output logic [7:0] e_txd,
    send_ctl_if.snd    ctl
);
    import eth_pkg::*;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PRE,
        PH_HDR,
        PH_PAY,
        PH_PAD,
        PH_FCS,
        PH_LAST,
        PH_HOLD
    } phase_t;

    phase_t       phase;
    logic [15:0]  cnt;
    logic [31:0]  crc;
    logic [31:0]  fcs;
    logic         rd_valid;
    logic [15:0]  eth_type;
    logic [111:0] hdr;
    logic [7:0]   hdr_byte;
    logic [7:0]   pay_byte;

    // bytewise crc-32, reflected
    function automatic logic [31:0] crc_next(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ CRC32_POLY) : (r >> 1);
        end
        return r;
    endfunction

    // ##############################
    // byte sources
    // ##############################
    assign eth_type = (ctl.kind == FK_ARP) ? ETH_TYPE_ARP : ETH_TYPE_IPV4;
    assign hdr      = {MAC_DST, MAC_SRC, eth_type};
    assign hdr_byte = hdr[8*(13 - cnt[3:0]) +: 8]; // msb first
    assign pay_byte = rd_valid ? rd_data : 8'h00;   // zeros on underrun
    assign fcs      = ~crc;
    assign e_txer   = 1'b0;

    // prefetch one ahead, the fifo read is registered
    assign rd_en = !empty && (((phase == PH_HDR) && (cnt == 16'd13)) ||
                              ((phase == PH_PAY) && (cnt < ctl.len - 16'd1)));

    // ##############################
    // serializer
    // ##############################
    always_ff @(posedge e_grxc or posedge rst) begin
        if (rst) begin
            phase    <= PH_IDLE;
            cnt      <= '0;
            crc      <= '1;
            rd_valid <= 1'b0;
            e_txen   <= 1'b0;
            e_txd    <= '0;
            ctl.done <= 1'b0;
        end else begin
            ctl.done <= 1'b0;
            rd_valid <= rd_en;
            case (phase)
                PH_IDLE: begin
                    if (ctl.start) begin
                        e_txen <= 1'b1;
                        e_txd  <= PREAMBLE_BYTE;
                        cnt    <= 16'd1;
                        phase  <= PH_PRE;
                    end
                end
                PH_PRE: begin
                    if (cnt == 16'd7) begin
                        e_txd <= SFD_BYTE;
                        crc   <= '1; // seed
                        cnt   <= '0;
                        phase <= PH_HDR;
                    end else begin
                        e_txd <= PREAMBLE_BYTE;
                        cnt   <= cnt + 16'd1;
                    end
                end
                PH_HDR: begin
                    e_txd <= hdr_byte;
                    crc   <= crc_next(crc, hdr_byte);
                    if (cnt == 16'd13) begin
                        cnt   <= '0;
                        phase <= PH_PAY;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                PH_PAY: begin
                    e_txd <= pay_byte;
                    crc   <= crc_next(crc, pay_byte);
                    if (cnt == ctl.len - 16'd1) begin
                        if (ctl.len < MIN_PAYLOAD) begin
                            cnt   <= cnt + 16'd1; // pad index runs on
                            phase <= PH_PAD;
                        end else begin
                            cnt   <= '0;
                            phase <= PH_FCS;
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                PH_PAD: begin
                    e_txd <= 8'h00;
                    crc   <= crc_next(crc, 8'h00);
                    if (cnt == MIN_PAYLOAD - 16'd1) begin
                        cnt   <= '0;
                        phase <= PH_FCS;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                PH_FCS: begin
                    e_txd <= fcs[8*cnt[1:0] +: 8]; // low byte first
                    if (cnt == 16'd3) phase <= PH_LAST;
                    else cnt <= cnt + 16'd1;
                end
                PH_LAST: begin
                    e_txen   <= 1'b0;
                    e_txd    <= '0;
                    ctl.done <= 1'b1;
                    phase    <= PH_HOLD;
                end
                PH_HOLD: if (!ctl.start) phase <= PH_IDLE; // start must drop first
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/payload_gen.sv
module payload_gen (
    input  logic        e_grxc,
    input  logic        rst,
    input  logic        fill_start,
    input  logic [15:0] fill_len,
    input  logic        full,
    output logic        fill_done,
    output logic        wr_en,
    output logic [7:0]  wr_data
);

    typedef enum logic [1:0] {
        PG_IDLE,
        PG_WRITE,
        PG_HOLD
    } pg_state_t;

    pg_state_t   state;
    logic [15:0] cnt;

    // one byte per cycle, stalled by full
    assign wr_en   = (state == PG_WRITE) && (cnt < fill_len) && !full;
    assign wr_data = cnt[7:0]; // counting pattern

    always_ff @(posedge e_grxc or posedge rst) begin
        if (rst) begin
            state     <= PG_IDLE;
            cnt       <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            case (state)
                PG_IDLE: begin
                    cnt <= '0;
                    if (fill_start) state <= PG_WRITE;
                end
                PG_WRITE: begin
                    if (cnt == fill_len) begin
                        fill_done <= 1'b1;
                        state     <= PG_HOLD;
                    end else if (wr_en) begin
                        cnt <= cnt + 16'd1;
                    end
                end
                PG_HOLD: if (!fill_start) state <= PG_IDLE; // wait for the level to drop
                default: state <= PG_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/send_ctl_if.sv
interface send_ctl_if;
    import eth_pkg::*;

    logic        start; // level, held through the frame
    frame_kind_t kind;
    logic [15:0] len;   // payload bytes, before padding
    logic        done;  // one cycle pulse

    modport seq (
        output start, kind, len,
        input  done
    );

    modport snd (
        input  start, kind, len,
        output done
    );

endinterface

// File: run_sim.sh
#!/bin/sh
# build and run the beacon testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f eth_beacon_top.f --top-module tb_eth_beacon -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_eth_beacon +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// File: verification/eth_beacon_props.sv
module eth_beacon_props #(
    parameter logic [15:0] PAYLOAD_LEN = 16'd64,
    parameter logic [31:0] REST_CYCLES = 32'd125_000_000
) (
    input logic       e_grxc,
    input logic       rst,
    input logic       e_txen,
    input logic       e_txer,
    input logic [7:0] e_txd
);
    timeunit 1ns;
    timeprecision 100ps;
    import eth_pkg::*;
    import beacon_pkg::*;

    int           err_cnt = 0;
    frame_kind_t  kind;       // kind of the burst in flight or next
    logic [15:0]  idx;        // byte position in the burst
    logic [31:0]  gap;
    logic         seen_burst;
    logic [31:0]  crc;
    logic [31:0]  fcs;
    logic [15:0]  len;
    logic [15:0]  body_len;   // payload plus pad
    logic [15:0]  burst_len;
    logic [15:0]  pay_idx;
    logic [111:0] hdr;
    logic [7:0]   exp_byte;

    // bit at a time, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c;
        for (int k = 0; k < 8; k++) begin
            if (r[0] ^ b[k]) r = (r >> 1) ^ CRC32_POLY;
            else r = r >> 1;
        end
        return r;
    endfunction

    assign len       = (kind == FK_ARP) ? ARP_LEN : PAYLOAD_LEN;
    assign body_len  = (len < MIN_PAYLOAD) ? MIN_PAYLOAD : len;
    assign burst_len = 16'd26 + body_len; // 8 framing, 14 header, 4 fcs
    assign pay_idx   = idx - 16'd22;
    assign fcs       = ~crc;
    assign hdr       = {MAC_DST, MAC_SRC, (kind == FK_ARP) ? ETH_TYPE_ARP : ETH_TYPE_IPV4};

    always_comb begin
        if (idx < 16'd7) exp_byte = PREAMBLE_BYTE;
        else if (idx == 16'd7) exp_byte = SFD_BYTE;
        else if (idx < 16'd22) exp_byte = 8'(hdr >> (8 * (21 - idx)));
        else if (pay_idx < len) exp_byte = pay_idx[7:0];
        else if (pay_idx < body_len) exp_byte = 8'h00;
        else exp_byte = 8'(fcs >> (8 * (pay_idx - body_len)));
    end

    // ##############################
    // burst tracking
    // ##############################
    always_ff @(posedge e_grxc or posedge rst) begin
        if (rst) begin
            idx        <= '0;
            gap        <= '0;
            seen_burst <= 1'b0;
            kind       <= FK_ARP;
            crc        <= '1;
        end else if (e_txen) begin
            idx        <= idx + 16'd1;
            gap        <= '0;
            seen_burst <= 1'b1;
            if (idx == 16'd7) crc <= '1; // sfd, seed for the next byte
            else if (idx >= 16'd8 && idx < 16'd22 + body_len) crc <= crc_byte(crc, e_txd);
        end else begin
            idx <= '0;
            if (gap != '1) gap <= gap + 32'd1;
            if (idx != 16'd0) kind <= (kind == FK_ARP) ? FK_IPV4 : FK_ARP; // burst ended
        end
    end

    // ##############################
    // port checks
    // ##############################
    a_rst_quiet: assert property (@(posedge e_grxc) rst || $past(rst) |-> !e_txen && !e_txer)
        else begin
            err_cnt++;
            $error("transmit active during or right after reset");
        end

    a_txer_low: assert property (@(posedge e_grxc) !e_txer)
        else begin
            err_cnt++;
            $error("e_txer went high");
        end

    a_header: assert property (@(posedge e_grxc) disable iff (rst)
        e_txen && idx < 16'd22 |-> e_txd == exp_byte)
        else begin
            err_cnt++;
            $error("framing or header byte %0d is %h, expected %h",
                $sampled(idx), $sampled(e_txd), $sampled(exp_byte));
        end

    a_payload: assert property (@(posedge e_grxc) disable iff (rst)
        e_txen && idx >= 16'd22 && pay_idx < body_len |-> e_txd == exp_byte)
        else begin
            err_cnt++;
            $error("payload byte %0d is %h, expected %h",
                $sampled(pay_idx), $sampled(e_txd), $sampled(exp_byte));
        end

    a_fcs: assert property (@(posedge e_grxc) disable iff (rst)
        e_txen && idx >= 16'd22 + body_len |-> e_txd == exp_byte)
        else begin
            err_cnt++;
            $error("fcs byte is %h, expected %h", $sampled(e_txd), $sampled(exp_byte));
        end

    a_burst_max: assert property (@(posedge e_grxc) disable iff (rst) e_txen |-> idx < burst_len)
        else begin
            err_cnt++;
            $error("burst longer than %0d cycles", $sampled(burst_len));
        end

    a_burst_len: assert property (@(posedge e_grxc) disable iff (rst)
        $fell(e_txen) |-> idx == burst_len)
        else begin
            err_cnt++;
            $error("burst of %0d cycles, expected %0d", $sampled(idx), $sampled(burst_len));
        end

    a_gap: assert property (@(posedge e_grxc) disable iff (rst)
        $rose(e_txen) && seen_burst |-> gap >= REST_CYCLES)
        else begin
            err_cnt++;
            $error("gap of %0d cycles between bursts is too short", $sampled(gap));
        end

endmodule

bind eth_beacon_top eth_beacon_props #(
    .PAYLOAD_LEN (PAYLOAD_LEN),
    .REST_CYCLES (REST_CYCLES)
) u_props (
    .e_grxc (e_grxc),
    .rst    (rst),
    .e_txen (e_txen),
    .e_txer (e_txer),
    .e_txd  (e_txd)
);

// File: verification/tb_eth_beacon.sv
module tb_eth_beacon;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] PAYLOAD_LEN = 16'd64;
    localparam logic [31:0] REST_CYCLES = 32'd40;
    localparam int          FIFO_DEPTH  = 128;
    localparam int          WATCHDOG_NS = 8 * (90 + int'(REST_CYCLES) + 80) * 4;
    localparam int          FIRST_RUN   = 3; // frames before the second reset
    localparam int          TOTAL       = 7;

    logic       e_grxc;
    logic       rst;
    logic       e_gtxc;
    logic       e_txen;
    logic       e_txer;
    logic [7:0] e_txd;

    logic [7:0] frame_q [$];
    int         frame_len [$];
    int         errors;
    int         total;

    eth_beacon_top #(
        .PAYLOAD_LEN (PAYLOAD_LEN),
        .REST_CYCLES (REST_CYCLES),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) UUT (
        .e_grxc (e_grxc),
        .rst    (rst),
        .e_gtxc (e_gtxc),
        .e_txen (e_txen),
        .e_txer (e_txer),
        .e_txd  (e_txd)
    );

    initial e_grxc = 1'b0;
    always #2 e_grxc = ~e_grxc;

    // the forwarded tx clock must track e_grxc
    always @(e_grxc) begin
        #1;
        assert (e_gtxc === e_grxc) else begin
            errors++;
            $display("FAIL %0t: e_gtxc is %b while e_grxc is %b", $time, e_gtxc, e_grxc);
        end
    end

    // frame monitor samples on the falling edge
    always @(negedge e_grxc) begin
        if (e_txen) begin
            frame_q.push_back(e_txd);
        end else if (frame_q.size() != 0) begin
            frame_len.push_back(frame_q.size());
            frame_q.delete();
        end
    end

    // n counts frames since the last reset and starts with arp
    function automatic int burst_cycles(input int n);
        int body;
        body = (n % 2 == 0) ? 28 : int'(PAYLOAD_LEN);
        if (body < 46) body = 46;
        return 8 + 14 + body + 4;
    endfunction

    task automatic wait_for_frames(input int n);
        while (frame_len.size() < n) @(posedge e_grxc);
    endtask

    task automatic hold_reset();
        #1 rst = 1'b1;
        repeat (5) @(posedge e_grxc);
        #1 rst = 1'b0;
    endtask

    task automatic check_frame_lengths();
        int pos;
        if (frame_len.size() != TOTAL) begin
            errors++;
            $display("FAIL %0t: %0d frames seen, expected %0d", $time, frame_len.size(), TOTAL);
        end
        for (int i = 0; i < frame_len.size(); i++) begin
            pos = (i < FIRST_RUN) ? i : i - FIRST_RUN;
            if (frame_len[i] != burst_cycles(pos)) begin
                errors++;
                $display("FAIL %0t: frame %0d has %0d bytes, expected %0d",
                    $time, i, frame_len[i], burst_cycles(pos));
            end
        end
    endtask

    initial begin
        errors = 0;
        rst    = 1'b1;
        repeat (5) @(posedge e_grxc);
        #1 rst = 1'b0;
        wait_for_frames(FIRST_RUN);
        @(posedge e_grxc);
        hold_reset(); // kind must restart at arp
        wait_for_frames(TOTAL);
        repeat (2) @(posedge e_grxc);
        check_frame_lengths();
        total = errors + UUT.u_props.err_cnt;
        $display("errors: %0d (frame checks %0d, assertions %0d)",
            total, errors, UUT.u_props.err_cnt);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the beacon did not send all expected frames in time");
        $display("TEST FAIL");
        $finish;
    end

endmodule
